// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

    // ----------------------------------------------------------------------
    // widths and reset values
    // ----------------------------------------------------------------------
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC   = 32'h0000_0000;
    // byte step between consecutive instructions
    localparam logic [XLEN-1:0] INST_BYTES = 32'd4;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ----------------------------------------------------------------------
    // major opcodes, inst[6:0]
    // ----------------------------------------------------------------------
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // ----------------------------------------------------------------------
    // funct3 meaning for OP and OP-IMM
    // ----------------------------------------------------------------------
    // add/sub and srl/sra are split by funct7 bit 5
    typedef enum logic [2:0] {
        FN_ADD  = 3'b000,
        FN_SLL  = 3'b001,
        FN_SLT  = 3'b010,
        FN_SLTU = 3'b011,
        FN_XOR  = 3'b100,
        FN_SR   = 3'b101,
        FN_OR   = 3'b110,
        FN_AND  = 3'b111
    } alu_fn_e;

endpackage

`default_nettype wire

// File: logic/decode_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface decode_bus_if;

    logic                 valid;
    core_pkg::word_t      pc;
    core_pkg::opcode_e    opcode;
    core_pkg::alu_fn_e    fn;
    // funct7 bit 5
    logic                 alt;
    core_pkg::word_t      imm;
    core_pkg::reg_addr_t  rd;
    core_pkg::reg_addr_t  rs1;
    core_pkg::reg_addr_t  rs2;
    // register values as read in the decode cycle
    core_pkg::word_t      rs1_val;
    core_pkg::word_t      rs2_val;

    modport producer (
        output valid, pc, opcode, fn, alt, imm, rd, rs1, rs2, rs1_val, rs2_val
    );

    modport consumer (
        input valid, pc, opcode, fn, alt, imm, rd, rs1, rs2, rs1_val, rs2_val
    );

endinterface

`default_nettype wire

// File: logic/inst_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module inst_fetch (
    input  wire logic             i_clk,
    input  wire logic             i_reset,
    input  wire logic             i_exec,

    // redirect from the ALU stage
    input  wire logic             i_flush,
    input  wire core_pkg::word_t  i_target_pc,

    // fetched word towards decode
    output logic                  o_valid,
    output core_pkg::word_t       o_pc,
    output core_pkg::word_t       o_inst,

    // wishbone classic read master
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output core_pkg::word_t       o_wb_adr,
    input  wire core_pkg::word_t  i_wb_dat,
    input  wire logic             i_wb_ack,

    output core_pkg::word_t       o_pc_next
);

    // DISCARD waits out a bus cycle whose data is on the wrong path
    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DISCARD
    } state_e;

    state_e          state;
    core_pkg::word_t pc;
    core_pkg::word_t adr;

    // ----------------------------------------------------------------------
    // control: state, pc and output valid
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= IDLE;
            pc      <= core_pkg::RESET_PC;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                IDLE: begin
                    // no start during a redirect, the address would be stale
                    if (i_exec && !i_flush) begin
                        state <= BUS;
                    end
                end
                BUS: begin
                    if (i_wb_ack) begin
                        state   <= IDLE;
                        o_valid <= !i_flush;
                    end else if (i_flush) begin
                        state <= DISCARD;
                    end
                end
                DISCARD: begin
                    if (i_wb_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (i_flush) begin
                pc <= i_target_pc;
            end else if (state == BUS && i_wb_ack) begin
                pc <= pc + core_pkg::INST_BYTES;
            end
        end
    end

    // ----------------------------------------------------------------------
    // address and fetched word
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        // address is frozen once the cycle opens
        if (state == IDLE) begin
            adr <= pc;
        end
        if (state == BUS && i_wb_ack) begin
            o_pc   <= pc;
            o_inst <= i_wb_dat;
        end
    end

    assign o_wb_cyc  = (state != IDLE);
    assign o_wb_stb  = (state != IDLE);
    assign o_wb_adr  = adr;
    assign o_pc_next = pc;

endmodule

`default_nettype wire

// File: logic/decode.sv
`timescale 1ns/1ns
`default_nettype none

module decode (
    input  wire logic                 i_clk,
    input  wire logic                 i_reset,
    input  wire logic                 i_flush,

    // from fetch
    input  wire logic                 i_valid,
    input  wire core_pkg::word_t      i_pc,
    input  wire core_pkg::word_t      i_inst,

    // register file read
    output core_pkg::reg_addr_t       o_rs1,
    output core_pkg::reg_addr_t       o_rs2,
    input  wire core_pkg::word_t      i_rs1_val,
    input  wire core_pkg::word_t      i_rs2_val,

    decode_bus_if.producer            o_bus
);

    core_pkg::opcode_e   opcode;
    core_pkg::alu_fn_e   fn;
    core_pkg::reg_addr_t rd;
    core_pkg::word_t     imm;
    logic                known;

    // ----------------------------------------------------------------------
    // field extraction
    // ----------------------------------------------------------------------
    assign opcode = core_pkg::opcode_e'(i_inst[6:0]);
    assign fn     = core_pkg::alu_fn_e'(i_inst[14:12]);
    assign rd     = i_inst[11:7];
    assign o_rs1  = i_inst[19:15];
    assign o_rs2  = i_inst[24:20];

    // immediate format by opcode
    always_comb begin
        imm   = '0;
        known = 1'b1;
        case (opcode)
            core_pkg::OPC_OP_IMM,
            core_pkg::OPC_JALR: begin
                imm = {{20{i_inst[31]}}, i_inst[31:20]};
            end
            core_pkg::OPC_LUI,
            core_pkg::OPC_AUIPC: begin
                imm = {i_inst[31:12], 12'h000};
            end
            core_pkg::OPC_JAL: begin
                imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20],
                       i_inst[30:21], 1'b0};
            end
            // register-register, no immediate
            core_pkg::OPC_OP: imm = '0;
            default: known = 1'b0;
        endcase
    end

    // ----------------------------------------------------------------------
    // pipeline register
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bus.valid <= 1'b0;
        end else begin
            o_bus.valid <= i_valid && !i_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_bus.pc      <= i_pc;
            o_bus.opcode  <= opcode;
            o_bus.fn      <= fn;
            o_bus.alt     <= i_inst[30];
            o_bus.imm     <= imm;
            // unknown opcodes retire without writing
            o_bus.rd      <= known ? rd : '0;
            o_bus.rs1     <= o_rs1;
            o_bus.rs2     <= o_rs2;
            o_bus.rs1_val <= i_rs1_val;
            o_bus.rs2_val <= i_rs2_val;
        end
    end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire logic           i_clk,
    input  wire logic           i_reset,

    decode_bus_if.consumer      i_bus,

    // jump redirect
    output logic                o_flush,
    output core_pkg::word_t     o_target_pc,

    // write-back
    output logic                o_wb_valid,
    output core_pkg::reg_addr_t o_wb_rd,
    output core_pkg::word_t     o_wb_val
);

    core_pkg::word_t rs1_fwd;
    core_pkg::word_t rs2_fwd;
    core_pkg::word_t op_b;
    core_pkg::word_t arith;
    core_pkg::word_t result;
    core_pkg::word_t jalr_sum;
    logic [4:0]      shamt;
    logic            is_sub;

    // ----------------------------------------------------------------------
    // forwarding from the write-back register
    // ----------------------------------------------------------------------
    // x0 is never forwarded
    assign rs1_fwd = (o_wb_valid && o_wb_rd != '0 && o_wb_rd == i_bus.rs1) ?
                     o_wb_val : i_bus.rs1_val;
    assign rs2_fwd = (o_wb_valid && o_wb_rd != '0 && o_wb_rd == i_bus.rs2) ?
                     o_wb_val : i_bus.rs2_val;

    assign op_b   = (i_bus.opcode == core_pkg::OPC_OP) ? rs2_fwd : i_bus.imm;
    assign shamt  = op_b[4:0];
    // bit 30 of an ADDI is immediate, so only OP subtracts
    assign is_sub = (i_bus.opcode == core_pkg::OPC_OP) && i_bus.alt;

    // ----------------------------------------------------------------------
    // integer unit
    // ----------------------------------------------------------------------
    always_comb begin
        arith = '0;
        case (i_bus.fn)
            core_pkg::FN_ADD:  arith = is_sub ? rs1_fwd - op_b : rs1_fwd + op_b;
            core_pkg::FN_SLL:  arith = rs1_fwd << shamt;
            core_pkg::FN_SLT:  arith = core_pkg::word_t'($signed(rs1_fwd) < $signed(op_b));
            core_pkg::FN_SLTU: arith = core_pkg::word_t'(rs1_fwd < op_b);
            core_pkg::FN_XOR:  arith = rs1_fwd ^ op_b;
            core_pkg::FN_SR: begin
                if (i_bus.alt) begin
                    arith = $signed(rs1_fwd) >>> shamt;
                end else begin
                    arith = rs1_fwd >> shamt;
                end
            end
            core_pkg::FN_OR:   arith = rs1_fwd | op_b;
            core_pkg::FN_AND:  arith = rs1_fwd & op_b;
            default:           arith = '0;
        endcase
    end

    // result select by opcode
    always_comb begin
        case (i_bus.opcode)
            core_pkg::OPC_OP_IMM,
            core_pkg::OPC_OP:    result = arith;
            core_pkg::OPC_LUI:   result = i_bus.imm;
            core_pkg::OPC_AUIPC: result = i_bus.pc + i_bus.imm;
            // link address
            core_pkg::OPC_JAL,
            core_pkg::OPC_JALR:  result = i_bus.pc + core_pkg::INST_BYTES;
            default:             result = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // jump resolution
    // ----------------------------------------------------------------------
    assign jalr_sum = rs1_fwd + i_bus.imm;
    assign o_flush  = i_bus.valid &&
                      (i_bus.opcode == core_pkg::OPC_JAL ||
                       i_bus.opcode == core_pkg::OPC_JALR);
    assign o_target_pc = (i_bus.opcode == core_pkg::OPC_JALR) ?
                         {jalr_sum[core_pkg::XLEN-1:1], 1'b0} :
                         i_bus.pc + i_bus.imm;

    // write-back register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= i_bus.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_rd  <= i_bus.rd;
        o_wb_val <= result;
    end

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  wire logic                 i_clk,
    input  wire logic                 i_reset,

    // decode read ports
    input  wire core_pkg::reg_addr_t  i_rs1,
    input  wire core_pkg::reg_addr_t  i_rs2,
    output core_pkg::word_t           o_rs1_val,
    output core_pkg::word_t           o_rs2_val,

    // write-back
    input  wire logic                 i_we,
    input  wire core_pkg::reg_addr_t  i_wr_addr,
    input  wire core_pkg::word_t      i_wr_data,

    // debug read
    input  wire core_pkg::reg_addr_t  i_dbg_addr,
    output core_pkg::word_t           o_dbg_data
);

    // x0 has no storage
    core_pkg::word_t regs [1:31];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_wr_addr != '0) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // write-first reads see the value under write
    assign o_rs1_val = (i_rs1 == '0) ? '0 :
                       (i_we && i_wr_addr == i_rs1) ? i_wr_data : regs[i_rs1];
    assign o_rs2_val = (i_rs2 == '0) ? '0 :
                       (i_we && i_wr_addr == i_rs2) ? i_wr_data : regs[i_rs2];

    assign o_dbg_data = (i_dbg_addr == '0) ? '0 : regs[i_dbg_addr];

endmodule

`default_nettype wire

// File: logic/core.sv
`timescale 1ns/1ns
`default_nettype none

module core (
    input  wire logic                 i_clk,
    input  wire logic                 i_reset,

    // run control and status
    input  wire logic                 i_exec,
    output core_pkg::word_t           o_pc,
    output logic                      o_fetch_wait,
    output logic                      o_flush,

    // debug register read
    input  wire core_pkg::reg_addr_t  i_dbg_addr,
    output core_pkg::word_t           o_dbg_data,

    // wishbone instruction bus
    output logic                      o_wb_cyc,
    output logic                      o_wb_stb,
    output logic                      o_wb_we,
    output core_pkg::word_t           o_wb_adr,
    input  wire core_pkg::word_t      i_wb_dat,
    input  wire logic                 i_wb_ack
);

    logic                f_valid;
    core_pkg::word_t     f_pc;
    core_pkg::word_t     f_inst;

    logic                flush;
    core_pkg::word_t     target_pc;

    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    core_pkg::word_t     rs1_val;
    core_pkg::word_t     rs2_val;

    logic                wb_valid;
    core_pkg::reg_addr_t wb_rd;
    core_pkg::word_t     wb_val;

    decode_bus_if u_dec_bus ();

    // ----------------------------------------------------------------------
    // pipeline stages
    // ----------------------------------------------------------------------
    inst_fetch u_inst_fetch (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_exec      (i_exec),
        .i_flush     (flush),
        .i_target_pc (target_pc),
        .o_valid     (f_valid),
        .o_pc        (f_pc),
        .o_inst      (f_inst),
        .o_wb_cyc    (o_wb_cyc),
        .o_wb_stb    (o_wb_stb),
        .o_wb_adr    (o_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .i_wb_ack    (i_wb_ack),
        .o_pc_next   (o_pc)
    );

    decode u_decode (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_flush   (flush),
        .i_valid   (f_valid),
        .i_pc      (f_pc),
        .i_inst    (f_inst),
        .o_rs1     (rs1),
        .o_rs2     (rs2),
        .i_rs1_val (rs1_val),
        .i_rs2_val (rs2_val),
        .o_bus     (u_dec_bus.producer)
    );

    alu u_alu (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_bus       (u_dec_bus.consumer),
        .o_flush     (flush),
        .o_target_pc (target_pc),
        .o_wb_valid  (wb_valid),
        .o_wb_rd     (wb_rd),
        .o_wb_val    (wb_val)
    );

    register_file u_register_file (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .o_rs1_val  (rs1_val),
        .o_rs2_val  (rs2_val),
        .i_we       (wb_valid),
        .i_wr_addr  (wb_rd),
        .i_wr_data  (wb_val),
        .i_dbg_addr (i_dbg_addr),
        .o_dbg_data (o_dbg_data)
    );

    // fetch side only reads
    assign o_wb_we      = 1'b0;
    assign o_fetch_wait = o_wb_cyc;
    assign o_flush      = flush;

endmodule

`default_nettype wire

// File: verification/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic o_clk,
    output logic o_reset
);

    // 10 ns period
    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // reset held for 10 rising edges, released just after the last one
    initial begin
        o_reset = 1'b1;
        repeat (10) @(posedge o_clk);
        #1;
        o_reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/tb_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core;

    localparam int unsigned SEED        = 93734;
    localparam int          RESET_LIMIT = 100;
    localparam int          RUN_LIMIT   = 5000;

    // one program row with fields as in the instruction
    typedef struct {
        core_pkg::opcode_e opc;
        core_pkg::alu_fn_e fn;
        logic              alt;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        core_pkg::word_t   imm;
    } row_t;

    logic                clk;
    logic                rst;
    logic                exec;
    core_pkg::word_t     pc_next;
    logic                fetch_wait;
    logic                flush;
    core_pkg::reg_addr_t dbg_addr;
    core_pkg::word_t     dbg_data;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    core_pkg::word_t     wb_adr;
    core_pkg::word_t     wb_dat;
    logic                wb_ack;

    row_t            rows [0:63];
    int              num_rows;
    core_pkg::word_t mem [0:255];
    core_pkg::word_t exp_regs [0:31];
    core_pkg::word_t loop_addr;
    int              exp_jumps;
    int              errors;
    int              checks;
    logic            timed_out;

    clock_gen u_clock_gen (
        .o_clk   (clk),
        .o_reset (rst)
    );

    core u_dut (
        .i_clk        (clk),
        .i_reset      (rst),
        .i_exec       (exec),
        .o_pc         (pc_next),
        .o_fetch_wait (fetch_wait),
        .o_flush      (flush),
        .i_dbg_addr   (dbg_addr),
        .o_dbg_data   (dbg_data),
        .o_wb_cyc     (wb_cyc),
        .o_wb_stb     (wb_stb),
        .o_wb_we      (wb_we),
        .o_wb_adr     (wb_adr),
        .i_wb_dat     (wb_dat),
        .i_wb_ack     (wb_ack)
    );

    task automatic check_value(input string what, input core_pkg::word_t got,
                               input core_pkg::word_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // ----------------------------------------------------------------------
    // program table
    // ----------------------------------------------------------------------
    task automatic add_row(input core_pkg::opcode_e opc, input core_pkg::alu_fn_e fn,
                           input logic alt, input int rd, input int rs1, input int rs2,
                           input int imm);
        rows[num_rows].opc = opc;
        rows[num_rows].fn  = fn;
        rows[num_rows].alt = alt;
        rows[num_rows].rd  = rd[4:0];
        rows[num_rows].rs1 = rs1[4:0];
        rows[num_rows].rs2 = rs2[4:0];
        rows[num_rows].imm = imm;
        num_rows++;
    endtask

    task automatic build_program();
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_ADD,  1'b0, 1, 0, 0, 100);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_ADD,  1'b0, 2, 0, 0, -7);
        // x2 straight from write-back
        add_row(core_pkg::OPC_OP,     core_pkg::FN_ADD,  1'b0, 3, 1, 2, 0);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_ADD,  1'b1, 4, 2, 1, 0);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_SLT,  1'b0, 5, 2, 1, 0);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_SLTU, 1'b0, 6, 2, 1, 0);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_XOR,  1'b0, 7, 1, 2, 0);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_OR,   1'b0, 8, 1, 2, 0);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_AND,  1'b0, 9, 1, 2, 0);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_ADD,  1'b0, 10, 0, 0, 3);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_SLL,  1'b0, 11, 2, 10, 0);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_SR,   1'b0, 12, 2, 10, 0);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_SR,   1'b1, 13, 2, 10, 0);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_SLT,  1'b0, 14, 2, 0, -1);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_SLTU, 1'b0, 15, 1, 0, -1);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_XOR,  1'b0, 16, 2, 0, 'h555);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_OR,   1'b0, 17, 1, 0, -256);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_AND,  1'b0, 18, 2, 0, 'h0f0);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_SLL,  1'b0, 19, 1, 0, 20);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_SR,   1'b0, 20, 2, 0, 28);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_SR,   1'b1, 21, 2, 0, 2);
        add_row(core_pkg::OPC_LUI,    core_pkg::FN_ADD,  1'b0, 22, 0, 0, 32'habcde000);
        add_row(core_pkg::OPC_AUIPC,  core_pkg::FN_ADD,  1'b0, 23, 0, 0, 32'h00001000);
        // write to x0, then read x0 back
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_ADD,  1'b0, 0, 1, 0, 55);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_ADD,  1'b0, 24, 0, 22, 0);
        // jal over two rows
        add_row(core_pkg::OPC_JAL,    core_pkg::FN_ADD,  1'b0, 25, 0, 0, 12);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_ADD,  1'b0, 26, 0, 0, 1);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_ADD,  1'b0, 27, 0, 0, 2);
        // jalr with an odd sum lands on row 32
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_ADD,  1'b0, 28, 0, 0, 120);
        add_row(core_pkg::OPC_JALR,   core_pkg::FN_ADD,  1'b0, 29, 28, 0, 9);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_ADD,  1'b0, 26, 0, 0, 3);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_ADD,  1'b0, 27, 0, 0, 4);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_ADD,  1'b0, 30, 29, 25, 0);
        add_row(core_pkg::OPC_OP_IMM, core_pkg::FN_ADD,  1'b0, 31, 30, 0, -1);
        add_row(core_pkg::OPC_OP,     core_pkg::FN_ADD,  1'b0, 31, 31, 31, 0);
        // self-loop marks the end
        add_row(core_pkg::OPC_JAL,    core_pkg::FN_ADD,  1'b0, 0, 0, 0, 0);
    endtask

    function automatic core_pkg::word_t assemble(input row_t r);
        core_pkg::word_t w;
        case (r.opc)
            core_pkg::OPC_OP_IMM: begin
                if (r.fn == core_pkg::FN_SLL || r.fn == core_pkg::FN_SR) begin
                    w = {1'b0, r.alt, 5'b00000, r.imm[4:0], r.rs1, r.fn, r.rd, r.opc};
                end else begin
                    w = {r.imm[11:0], r.rs1, r.fn, r.rd, r.opc};
                end
            end
            core_pkg::OPC_OP: begin
                w = {1'b0, r.alt, 5'b00000, r.rs2, r.rs1, r.fn, r.rd, r.opc};
            end
            core_pkg::OPC_LUI,
            core_pkg::OPC_AUIPC: begin
                w = {r.imm[31:12], r.rd, r.opc};
            end
            core_pkg::OPC_JAL: begin
                w = {r.imm[20], r.imm[10:1], r.imm[11], r.imm[19:12], r.rd, r.opc};
            end
            default: begin
                w = {r.imm[11:0], r.rs1, 3'b000, r.rd, r.opc};
            end
        endcase
        return w;
    endfunction

    task automatic load_memory();
        // opcode 0 is unknown, so unused words retire as no-ops
        for (int i = 0; i < 256; i++) begin
            mem[i] = i << 7;
        end
        for (int i = 0; i < num_rows; i++) begin
            mem[i] = assemble(rows[i]);
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic core_pkg::word_t alu_result(input row_t r, input core_pkg::word_t a,
                                                   input core_pkg::word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (r.fn)
            core_pkg::FN_ADD:  return (r.opc == core_pkg::OPC_OP && r.alt) ? a - b : a + b;
            core_pkg::FN_SLL:  return a << sh;
            core_pkg::FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            core_pkg::FN_SLTU: return (a < b) ? 32'd1 : 32'd0;
            core_pkg::FN_XOR:  return a ^ b;
            core_pkg::FN_SR: begin
                if (r.alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            core_pkg::FN_OR:   return a | b;
            default:           return a & b;
        endcase
    endfunction

    task automatic run_model();
        core_pkg::word_t pc;
        core_pkg::word_t next_pc;
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t res;
        row_t            r;
        int              steps;

        for (int i = 0; i < 32; i++) begin
            exp_regs[i] = '0;
        end
        pc        = core_pkg::RESET_PC;
        steps     = 0;
        exp_jumps = 0;
        while (pc != loop_addr && steps < 200) begin
            r       = rows[pc[7:2]];
            a       = exp_regs[r.rs1];
            b       = (r.opc == core_pkg::OPC_OP) ? exp_regs[r.rs2] : r.imm;
            next_pc = pc + 32'd4;
            case (r.opc)
                core_pkg::OPC_LUI:   res = r.imm;
                core_pkg::OPC_AUIPC: res = pc + r.imm;
                core_pkg::OPC_JAL: begin
                    res     = pc + 32'd4;
                    next_pc = pc + r.imm;
                    exp_jumps++;
                end
                core_pkg::OPC_JALR: begin
                    res     = pc + 32'd4;
                    next_pc = (a + r.imm) & ~32'd1;
                    exp_jumps++;
                end
                default: res = alu_result(r, a, b);
            endcase
            if (r.rd != 5'd0) begin
                exp_regs[r.rd] = res;
            end
            pc = next_pc;
            steps++;
        end
        if (pc != loop_addr) begin
            errors++;
            $display("reference model never reached the end of the program");
        end
    endtask

    // ----------------------------------------------------------------------
    // wishbone memory with 0 to 3 wait states per access
    // ----------------------------------------------------------------------
    initial begin : wishbone_memory
        int              wait_left;
        logic            pending;
        core_pkg::word_t held_adr;

        wb_ack    = 1'b0;
        wb_dat    = '0;
        pending   = 1'b0;
        wait_left = 0;
        held_adr  = '0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            #1;
            if (wb_ack) begin
                wb_ack  = 1'b0;
                wb_dat  = '0;
                pending = 1'b0;
                // master must close the cycle for at least one cycle
                check_value("o_wb_cyc after ack", {31'b0, wb_cyc}, 32'd0);
                check_value("o_fetch_wait after ack", {31'b0, fetch_wait}, 32'd0);
            end else if (wb_cyc && wb_stb) begin
                if (!pending) begin
                    pending   = 1'b1;
                    held_adr  = wb_adr;
                    wait_left = $urandom_range(3, 0);
                    check_value("o_wb_we during a fetch", {31'b0, wb_we}, 32'd0);
                end else begin
                    check_value("wishbone address during a cycle", wb_adr, held_adr);
                end
                check_value("o_fetch_wait during a cycle", {31'b0, fetch_wait}, 32'd1);
                if (wait_left == 0) begin
                    wb_ack = 1'b1;
                    wb_dat = mem[wb_adr[9:2]];
                end else begin
                    wait_left--;
                end
            end else if (pending) begin
                errors++;
                pending = 1'b0;
                $display("wishbone cycle was dropped before ack at %0t ns", $time);
            end
        end
    end

    // ----------------------------------------------------------------------
    // run control
    // ----------------------------------------------------------------------
    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < RESET_LIMIT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (rst !== 1'b0) begin
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end
    endtask

    task automatic check_reset_state();
        check_value("o_wb_cyc after reset", {31'b0, wb_cyc}, 32'd0);
        check_value("o_wb_stb after reset", {31'b0, wb_stb}, 32'd0);
        check_value("o_wb_we after reset", {31'b0, wb_we}, 32'd0);
        check_value("o_fetch_wait after reset", {31'b0, fetch_wait}, 32'd0);
        check_value("o_flush after reset", {31'b0, flush}, 32'd0);
        check_value("o_pc after reset", pc_next, core_pkg::RESET_PC);
    endtask

    // the second arrival at the self-loop follows its first execution
    task automatic wait_for_loop();
        core_pkg::word_t prev_pc;
        logic            prev_flush;
        int              hits;
        int              flushes;
        int              cycles;
        hits       = 0;
        flushes    = 0;
        cycles     = 0;
        prev_pc    = pc_next;
        prev_flush = 1'b0;
        while (hits < 2 && cycles < RUN_LIMIT) begin
            @(posedge clk);
            #2;
            if (flush && !prev_flush) begin
                flushes++;
            end
            if (pc_next == loop_addr && prev_pc != loop_addr) begin
                hits++;
            end
            prev_flush = flush;
            prev_pc    = pc_next;
            cycles++;
        end
        if (hits < 2) begin
            timed_out = 1'b1;
            $display("timeout: the program never reached its final self-loop");
        end else begin
            // each taken jump plus the first pass through the self-loop
            check_value("o_flush pulses", flushes, exp_jumps + 1);
        end
    endtask

    task automatic read_registers();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #1;
            dbg_addr = r[4:0];
            #4;
            check_value($sformatf("x%0d", r), dbg_data, exp_regs[r]);
        end
    endtask

    initial begin
        exec      = 1'b0;
        dbg_addr  = '0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        num_rows  = 0;
        exp_jumps = 0;

        build_program();
        loop_addr = (num_rows - 1) * 4;
        load_memory();
        run_model();

        wait_for_reset();
        if (!timed_out) begin
            check_reset_state();
            @(posedge clk);
            #1;
            exec = 1'b1;
            wait_for_loop();
        end
        if (!timed_out) begin
            read_registers();
        end
        if (timed_out) begin
            errors++;
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
logic/core_pkg.sv
logic/decode_bus_if.sv
logic/inst_fetch.sv
logic/decode.sv
logic/alu.sv
logic/register_file.sv
logic/core.sv
verification/clock_gen.sv
verification/tb_core.sv

// File: Makefile
# Verilator flow for the RV32I core and its testbench

VERILATOR  ?= verilator
TOP        ?= tb_core
RTL_TOP    ?= core
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?=
FAIL_MSG   ?= ERRORS FOUND
PASS_MSG   ?= NO ERRORS

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter logic/%,$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing $(SIM_FLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
